//--- verilog/rv_pkg.sv
package rv_pkg;

	// major opcodes of the RV32I base set
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// compare ops return 0 or 1 in bit 0
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_EQ     = 4'd10,
		ALU_NE     = 4'd11,
		ALU_GE     = 4'd12,
		ALU_GEU    = 4'd13,
		ALU_PASS_B = 4'd14
	} alu_op_e;

	// the instruction format picks the immediate layout
	typedef enum logic [2:0] {
		TYPE_NONE = 3'd0,
		TYPE_R    = 3'd1,
		TYPE_I    = 3'd2,
		TYPE_S    = 3'd3,
		TYPE_B    = 3'd4,
		TYPE_U    = 3'd5,
		TYPE_J    = 3'd6
	} instr_type_e;

	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_READ  = 2'd1,
		MEM_WRITE = 2'd2
	} mem_access_e;

	// the U forms are only meaningful for loads
	typedef enum logic [2:0] {
		SIZE_BYTE  = 3'd0,
		SIZE_HALF  = 3'd1,
		SIZE_WORD  = 3'd2,
		SIZE_UBYTE = 3'd4,
		SIZE_UHALF = 3'd5
	} mem_size_e;

	// writeback source
	typedef enum logic [1:0] {
		WB_ALU      = 2'd0,
		WB_MEM      = 2'd1,
		WB_PC_PLUS4 = 2'd2
	} wb_sel_e;

endpackage

//--- verilog/decoder.sv
`timescale 1ns/100ps

module decoder (
	input  logic [31:0]          i_instr,
	output logic [4:0]           o_rs1,
	output logic [4:0]           o_rs2,
	output logic [4:0]           o_rd,
	output logic [31:0]          o_imm,
	output rv_pkg::alu_op_e      o_alu_op,
	output logic                 o_a_pc,
	output logic                 o_b_imm,
	output rv_pkg::mem_access_e  o_mem_access,
	output rv_pkg::mem_size_e    o_mem_size,
	output rv_pkg::wb_sel_e      o_wb_sel,
	output logic                 o_reg_write,
	output logic                 o_is_branch,
	output logic                 o_is_jump,
	output logic                 o_is_jalr
);

	rv_pkg::opcode_e     opcode;
	rv_pkg::instr_type_e fmt;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic                legal;
	logic                use_shamt;

	assign opcode = rv_pkg::opcode_e'(i_instr[6:0]);
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	assign o_rs1 = i_instr[19:15];
	assign o_rs2 = i_instr[24:20];
	assign o_rd  = i_instr[11:7];

	// immediate by format
	always_comb begin
		case (fmt)
			rv_pkg::TYPE_I: o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
			rv_pkg::TYPE_S: o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			rv_pkg::TYPE_B: o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
				i_instr[30:25], i_instr[11:8], 1'b0};
			rv_pkg::TYPE_U: o_imm = {i_instr[31:12], 12'b0};
			rv_pkg::TYPE_J: o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
				i_instr[20], i_instr[30:21], 1'b0};
			default:        o_imm = 32'b0;
		endcase
		// immediate shifts only carry a 5-bit shift amount
		if (use_shamt) begin
			o_imm = {27'b0, i_instr[24:20]};
		end
	end

	always_comb begin
		fmt          = rv_pkg::TYPE_NONE;
		legal        = 1'b1;
		use_shamt    = 1'b0;
		o_alu_op     = rv_pkg::ALU_ADD;
		o_a_pc       = 1'b0;
		o_b_imm      = 1'b0;
		o_mem_access = rv_pkg::MEM_NONE;
		o_mem_size   = rv_pkg::SIZE_WORD;
		o_wb_sel     = rv_pkg::WB_ALU;
		o_reg_write  = 1'b0;
		o_is_branch  = 1'b0;
		o_is_jump    = 1'b0;
		o_is_jalr    = 1'b0;

		case (opcode)
			rv_pkg::OPC_LUI: begin
				fmt         = rv_pkg::TYPE_U;
				o_alu_op    = rv_pkg::ALU_PASS_B;
				o_b_imm     = 1'b1;
				o_reg_write = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				fmt         = rv_pkg::TYPE_U;
				o_a_pc      = 1'b1;
				o_b_imm     = 1'b1;
				o_reg_write = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				fmt         = rv_pkg::TYPE_J;
				o_a_pc      = 1'b1;
				o_b_imm     = 1'b1;
				o_wb_sel    = rv_pkg::WB_PC_PLUS4;
				o_reg_write = 1'b1;
				o_is_jump   = 1'b1;
			end
			rv_pkg::OPC_JALR: begin
				// alu forms rs1 + imm as the jump target
				fmt         = rv_pkg::TYPE_I;
				legal       = (funct3 == 3'b000);
				o_b_imm     = 1'b1;
				o_wb_sel    = rv_pkg::WB_PC_PLUS4;
				o_reg_write = 1'b1;
				o_is_jump   = 1'b1;
				o_is_jalr   = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				fmt         = rv_pkg::TYPE_B;
				o_is_branch = 1'b1;
				case (funct3)
					3'b000:  o_alu_op = rv_pkg::ALU_EQ;
					3'b001:  o_alu_op = rv_pkg::ALU_NE;
					3'b100:  o_alu_op = rv_pkg::ALU_SLT;
					3'b101:  o_alu_op = rv_pkg::ALU_GE;
					3'b110:  o_alu_op = rv_pkg::ALU_SLTU;
					3'b111:  o_alu_op = rv_pkg::ALU_GEU;
					default: legal = 1'b0;
				endcase
			end
			rv_pkg::OPC_LOAD: begin
				fmt          = rv_pkg::TYPE_I;
				o_b_imm      = 1'b1;
				o_mem_access = rv_pkg::MEM_READ;
				o_wb_sel     = rv_pkg::WB_MEM;
				o_reg_write  = 1'b1;
				case (funct3)
					3'b000:  o_mem_size = rv_pkg::SIZE_BYTE;
					3'b001:  o_mem_size = rv_pkg::SIZE_HALF;
					3'b010:  o_mem_size = rv_pkg::SIZE_WORD;
					3'b100:  o_mem_size = rv_pkg::SIZE_UBYTE;
					3'b101:  o_mem_size = rv_pkg::SIZE_UHALF;
					default: legal = 1'b0;
				endcase
			end
			rv_pkg::OPC_STORE: begin
				fmt          = rv_pkg::TYPE_S;
				o_b_imm      = 1'b1;
				o_mem_access = rv_pkg::MEM_WRITE;
				case (funct3)
					3'b000:  o_mem_size = rv_pkg::SIZE_BYTE;
					3'b001:  o_mem_size = rv_pkg::SIZE_HALF;
					3'b010:  o_mem_size = rv_pkg::SIZE_WORD;
					default: legal = 1'b0;
				endcase
			end
			rv_pkg::OPC_OP_IMM: begin
				fmt         = rv_pkg::TYPE_I;
				o_b_imm     = 1'b1;
				o_reg_write = 1'b1;
				case (funct3)
					3'b000: o_alu_op = rv_pkg::ALU_ADD;
					3'b001: begin
						o_alu_op  = rv_pkg::ALU_SLL;
						use_shamt = 1'b1;
						legal     = (funct7 == 7'b0000000);
					end
					3'b010: o_alu_op = rv_pkg::ALU_SLT;
					3'b011: o_alu_op = rv_pkg::ALU_SLTU;
					3'b100: o_alu_op = rv_pkg::ALU_XOR;
					3'b101: begin
						use_shamt = 1'b1;
						if (funct7 == 7'b0000000) begin
							o_alu_op = rv_pkg::ALU_SRL;
						end else if (funct7 == 7'b0100000) begin
							o_alu_op = rv_pkg::ALU_SRA;
						end else begin
							legal = 1'b0;
						end
					end
					3'b110: o_alu_op = rv_pkg::ALU_OR;
					default: o_alu_op = rv_pkg::ALU_AND;
				endcase
			end
			rv_pkg::OPC_OP: begin
				fmt         = rv_pkg::TYPE_R;
				o_reg_write = 1'b1;
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000:  o_alu_op = rv_pkg::ALU_ADD;
						3'b001:  o_alu_op = rv_pkg::ALU_SLL;
						3'b010:  o_alu_op = rv_pkg::ALU_SLT;
						3'b011:  o_alu_op = rv_pkg::ALU_SLTU;
						3'b100:  o_alu_op = rv_pkg::ALU_XOR;
						3'b101:  o_alu_op = rv_pkg::ALU_SRL;
						3'b110:  o_alu_op = rv_pkg::ALU_OR;
						default: o_alu_op = rv_pkg::ALU_AND;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					o_alu_op = rv_pkg::ALU_SUB;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
					o_alu_op = rv_pkg::ALU_SRA;
				end else begin
					legal = 1'b0;
				end
			end
			default: legal = 1'b0;
		endcase

		// illegal encodings fall through as a plain pc + 4
		if (!legal) begin
			o_mem_access = rv_pkg::MEM_NONE;
			o_wb_sel     = rv_pkg::WB_ALU;
			o_reg_write  = 1'b0;
			o_is_branch  = 1'b0;
			o_is_jump    = 1'b0;
			o_is_jalr    = 1'b0;
		end
	end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic        clk,
	input  logic        i_rst_n,
	input  logic [4:0]  i_rs1,
	input  logic [4:0]  i_rs2,
	input  logic [4:0]  i_rd,
	input  logic        i_we,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata1,
	output logic [31:0] o_rdata2
);

	logic [31:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (i_we && i_rd != 5'd0) begin
			// x0 is never written
			regs[i_rd] <= i_wdata;
		end
	end

	// reads of x0 always return zero
	assign o_rdata1 = (i_rs1 == 5'd0) ? 32'b0 : regs[i_rs1];
	assign o_rdata2 = (i_rs2 == 5'd0) ? 32'b0 : regs[i_rs2];

endmodule

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu (
	input  rv_pkg::alu_op_e i_op,
	input  logic [31:0]     i_a,
	input  logic [31:0]     i_b,
	output logic [31:0]     o_result
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// only the low five bits shift
	assign shamt       = i_b[4:0];
	assign lt_signed   = $signed(i_a) < $signed(i_b);
	assign lt_unsigned = i_a < i_b;

	always_comb begin
		case (i_op)
			rv_pkg::ALU_ADD:    o_result = i_a + i_b;
			rv_pkg::ALU_SUB:    o_result = i_a - i_b;
			rv_pkg::ALU_SLL:    o_result = i_a << shamt;
			rv_pkg::ALU_SRL:    o_result = i_a >> shamt;
			rv_pkg::ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
			rv_pkg::ALU_XOR:    o_result = i_a ^ i_b;
			rv_pkg::ALU_OR:     o_result = i_a | i_b;
			rv_pkg::ALU_AND:    o_result = i_a & i_b;
			// compares put their result in bit 0
			rv_pkg::ALU_SLT:    o_result = {31'b0, lt_signed};
			rv_pkg::ALU_SLTU:   o_result = {31'b0, lt_unsigned};
			rv_pkg::ALU_EQ:     o_result = {31'b0, i_a == i_b};
			rv_pkg::ALU_NE:     o_result = {31'b0, i_a != i_b};
			rv_pkg::ALU_GE:     o_result = {31'b0, !lt_signed};
			rv_pkg::ALU_GEU:    o_result = {31'b0, !lt_unsigned};
			rv_pkg::ALU_PASS_B: o_result = i_b;
			default:            o_result = 32'b0;
		endcase
	end

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
	parameter int RAM_WORDS = 64
) (
	input  logic              clk,
	input  logic              i_rst_n,
	input  logic [31:0]       i_addr,
	input  logic [31:0]       i_wdata,
	input  rv_pkg::mem_size_e i_size,
	input  logic              i_we,
	output logic [31:0]       o_rdata
);

	localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	logic [31:0]      mem [0:RAM_WORDS-1];
	logic [IDX_W-1:0] word_idx;
	logic [3:0]       lane_en;
	logic [31:0]      lane_data;
	logic [31:0]      rd_word;
	logic [7:0]       rd_byte;
	logic [15:0]      rd_half;

	// depth need not be a power of two
	assign word_idx = IDX_W'((i_addr >> 2) % RAM_WORDS);

	// byte lanes and replicated store data
	always_comb begin
		case (i_size)
			rv_pkg::SIZE_BYTE, rv_pkg::SIZE_UBYTE: begin
				lane_en   = 4'b0001 << i_addr[1:0];
				lane_data = {4{i_wdata[7:0]}};
			end
			rv_pkg::SIZE_HALF, rv_pkg::SIZE_UHALF: begin
				lane_en   = i_addr[1] ? 4'b1100 : 4'b0011;
				lane_data = {2{i_wdata[15:0]}};
			end
			default: begin
				lane_en   = 4'b1111;
				lane_data = i_wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < RAM_WORDS; i++) begin
				mem[i] <= 32'b0;
			end
		end else if (i_we) begin
			for (int b = 0; b < 4; b++) begin
				if (lane_en[b]) begin
					mem[word_idx][b*8 +: 8] <= lane_data[b*8 +: 8];
				end
			end
		end
	end

	assign rd_word = mem[word_idx];
	assign rd_byte = rd_word[i_addr[1:0]*8 +: 8];
	assign rd_half = i_addr[1] ? rd_word[31:16] : rd_word[15:0];

	always_comb begin
		case (i_size)
			rv_pkg::SIZE_BYTE:  o_rdata = {{24{rd_byte[7]}}, rd_byte};
			rv_pkg::SIZE_UBYTE: o_rdata = {24'b0, rd_byte};
			rv_pkg::SIZE_HALF:  o_rdata = {{16{rd_half[15]}}, rd_half};
			rv_pkg::SIZE_UHALF: o_rdata = {16'b0, rd_half};
			default:            o_rdata = rd_word;
		endcase
	end

endmodule

//--- verilog/exec_core.sv
`timescale 1ns/100ps

module exec_core #(
	parameter int RAM_WORDS = 64
) (
	input  logic        clk,
	input  logic        i_rst_n,
	input  logic        i_valid,
	input  logic [31:0] i_instr,
	input  logic [31:0] i_pc,
	output logic        o_done,
	output logic        o_wb_en,
	output logic [4:0]  o_wb_rd,
	output logic [31:0] o_wb_data,
	output logic [31:0] o_next_pc
);

	logic [4:0]          rs1;
	logic [4:0]          rs2;
	logic [4:0]          rd;
	logic [31:0]         imm;
	rv_pkg::alu_op_e     alu_op;
	logic                a_pc;
	logic                b_imm;
	rv_pkg::mem_access_e mem_access;
	rv_pkg::mem_size_e   mem_size;
	rv_pkg::wb_sel_e     wb_sel;
	logic                reg_write;
	logic                is_branch;
	logic                is_jump;
	logic                is_jalr;
	logic [31:0]         rdata1;
	logic [31:0]         rdata2;
	logic [31:0]         op_a;
	logic [31:0]         op_b;
	logic [31:0]         alu_result;
	logic [31:0]         load_data;
	logic [31:0]         wb_data;
	logic [31:0]         pc_plus4;
	logic [31:0]         branch_target;
	logic [31:0]         next_pc;
	logic                taken;

	decoder u_decoder (
		.i_instr      (i_instr),
		.o_rs1        (rs1),
		.o_rs2        (rs2),
		.o_rd         (rd),
		.o_imm        (imm),
		.o_alu_op     (alu_op),
		.o_a_pc       (a_pc),
		.o_b_imm      (b_imm),
		.o_mem_access (mem_access),
		.o_mem_size   (mem_size),
		.o_wb_sel     (wb_sel),
		.o_reg_write  (reg_write),
		.o_is_branch  (is_branch),
		.o_is_jump    (is_jump),
		.o_is_jalr    (is_jalr)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_rs1    (rs1),
		.i_rs2    (rs2),
		.i_rd     (rd),
		.i_we     (reg_write & i_valid),
		.i_wdata  (wb_data),
		.o_rdata1 (rdata1),
		.o_rdata2 (rdata2)
	);

	assign op_a = a_pc ? i_pc : rdata1;
	assign op_b = b_imm ? imm : rdata2;

	alu u_alu (
		.i_op     (alu_op),
		.i_a      (op_a),
		.i_b      (op_b),
		.o_result (alu_result)
	);

	// the alu result is the load or store address
	data_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_data_ram (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_addr  (alu_result),
		.i_wdata (rdata2),
		.i_size  (mem_size),
		.i_we    ((mem_access == rv_pkg::MEM_WRITE) && i_valid),
		.o_rdata (load_data)
	);

	assign pc_plus4      = i_pc + 32'd4;
	assign branch_target = i_pc + imm;
	assign taken         = is_branch & alu_result[0];

	always_comb begin
		case (wb_sel)
			rv_pkg::WB_MEM:      wb_data = load_data;
			rv_pkg::WB_PC_PLUS4: wb_data = pc_plus4;
			default:             wb_data = alu_result;
		endcase
	end

	// jalr target comes out of the alu with bit 0 cleared
	always_comb begin
		if (is_jalr) begin
			next_pc = {alu_result[31:1], 1'b0};
		end else if (is_jump || taken) begin
			next_pc = branch_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_done  <= 1'b0;
			o_wb_en <= 1'b0;
		end else begin
			o_done  <= i_valid;
			o_wb_en <= i_valid & reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_wb_rd   <= rd;
			o_wb_data <= wb_data;
			o_next_pc <= next_pc;
		end
	end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	// reset low for the first cycles, released on a rising edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

//--- bench/tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core;

	localparam int NAME_W = 8 * 16;

	logic        clk;
	logic        rst_n;
	logic        i_valid;
	logic [31:0] i_instr;
	logic [31:0] i_pc;
	logic        o_done;
	logic        o_wb_en;
	logic [4:0]  o_wb_rd;
	logic [31:0] o_wb_data;
	logic [31:0] o_next_pc;

	// one entry per vector line
	logic [NAME_W-1:0] v_name[$];
	logic [31:0]       v_instr[$];
	logic [31:0]       v_pc[$];
	logic              v_wb_en[$];
	logic [4:0]        v_rd[$];
	logic [31:0]       v_data[$];
	logic [31:0]       v_next_pc[$];

	int cycle_count = 0;
	int cycle_limit = 0;
	int seed        = 66;

	tb_clock u_clock (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	exec_core #(
		.RAM_WORDS (64)
	) uut (
		.clk       (clk),
		.i_rst_n   (rst_n),
		.i_valid   (i_valid),
		.i_instr   (i_instr),
		.i_pc      (i_pc),
		.o_done    (o_done),
		.o_wb_en   (o_wb_en),
		.o_wb_rd   (o_wb_rd),
		.o_wb_data (o_wb_data),
		.o_next_pc (o_next_pc)
	);

	task automatic report_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_word(input logic [NAME_W-1:0] test, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH %0s %s: expected %h actual %h", test, field, exp, act);
			report_failure();
		end
	endtask

	task automatic check_reg(input logic [NAME_W-1:0] test, input string field,
		input logic [4:0] exp, input logic [4:0] act);
		if (exp !== act) begin
			$display("MISMATCH %0s %s: expected %0d actual %0d", test, field, exp, act);
			report_failure();
		end
	endtask

	task automatic check_flag(input logic [NAME_W-1:0] test, input string field,
		input logic exp, input logic act);
		if (exp !== act) begin
			$display("MISMATCH %0s %s: expected %b actual %b", test, field, exp, act);
			report_failure();
		end
	endtask

	// rd and data only mean something when a writeback is expected
	task automatic verify_outputs(input int idx);
		check_flag(v_name[idx], "done", 1'b1, o_done);
		check_flag(v_name[idx], "wb_en", v_wb_en[idx], o_wb_en);
		if (v_wb_en[idx]) begin
			check_reg(v_name[idx], "wb_rd", v_rd[idx], o_wb_rd);
			check_word(v_name[idx], "wb_data", v_data[idx], o_wb_data);
		end
		check_word(v_name[idx], "next_pc", v_next_pc[idx], o_next_pc);
	endtask

	task automatic expect_idle();
		check_flag("idle", "done", 1'b0, o_done);
		check_flag("idle", "wb_en", 1'b0, o_wb_en);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			report_failure();
		end
	end

	initial begin
		int                fd;
		int                code;
		int                n;
		int                k;
		int                gap;
		int                prev;
		int                cur;
		logic [8*200-1:0]  line_buf;
		logic [NAME_W-1:0] t_name;
		logic [31:0]       t_instr;
		logic [31:0]       t_pc;
		logic              t_wb_en;
		logic [4:0]        t_rd;
		logic [31:0]       t_data;
		logic [31:0]       t_next_pc;

		i_valid = 1'b0;
		i_instr = 32'b0;
		i_pc    = 32'b0;

		fd = $fopen("bench/exec_core_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file bench/exec_core_vectors.txt");
			report_failure();
		end
		// comment and blank lines do not yield all seven fields
		while (!$feof(fd)) begin
			line_buf = '0;
			if ($fgets(line_buf, fd) > 0) begin
				code = $sscanf(line_buf, "%s %h %h %h %h %h %h", t_name, t_instr, t_pc,
					t_wb_en, t_rd, t_data, t_next_pc);
				if (code == 7) begin
					v_name.push_back(t_name);
					v_instr.push_back(t_instr);
					v_pc.push_back(t_pc);
					v_wb_en.push_back(t_wb_en);
					v_rd.push_back(t_rd);
					v_data.push_back(t_data);
					v_next_pc.push_back(t_next_pc);
				end
			end
		end
		$fclose(fd);

		n = v_instr.size();
		if (n == 0) begin
			$display("the vector file holds no test vectors");
			report_failure();
		end
		cycle_limit = n * 5 + 20;

		while (!rst_n) @(posedge clk);

		// a strobe driven at one edge is sampled at the next and checked after it
		k    = 0;
		prev = -1;
		gap  = $unsigned($random(seed)) % 4;
		while (k < n || prev >= 0) begin
			@(posedge clk);
			cur = -1;
			if (k < n && gap == 0) begin
				i_valid <= 1'b1;
				i_instr <= v_instr[k];
				i_pc    <= v_pc[k];
				cur = k;
				k++;
				gap = $unsigned($random(seed)) % 4;
			end else begin
				i_valid <= 1'b0;
				if (gap > 0) begin
					gap--;
				end
			end
			@(negedge clk);
			if (prev >= 0) begin
				verify_outputs(prev);
			end else begin
				expect_idle();
			end
			prev = cur;
		end

		$display("All checks passed");
		$finish;
	end

endmodule

//--- bench/exec_core_vectors.txt
# test instr pc wb_en rd wb_data next_pc, all hex
# rd and wb_data are not compared when wb_en is 0
addi_pos 00500093 00000100 1 01 00000005 00000104
addi_neg ffd00113 00000104 1 02 fffffffd 00000108
lui 800001b7 00000108 1 03 80000000 0000010c
auipc 00001217 0000010c 1 04 0000110c 00000110
srai_neg 4041d293 00000110 1 05 f8000000 00000114
add 00208333 00000114 1 06 00000002 00000118
sub 402083b3 00000118 1 07 00000008 0000011c
xor 0020c433 0000011c 1 08 fffffff8 00000120
slt 001124b3 00000120 1 09 00000001 00000124
sltu 00113533 00000124 1 0a 00000000 00000128
addi_x80 08000593 00000128 1 0b 00000080 0000012c
sb 00b002a3 0000012c 0 00 00000000 00000130
lb 00500603 00000130 1 0c ffffff80 00000134
lbu 00504683 00000134 1 0d 00000080 00000138
sh 00201523 00000138 0 00 00000000 0000013c
lh 00a01703 0000013c 1 0e fffffffd 00000140
lhu 00a05783 00000140 1 0f 0000fffd 00000144
beq_taken 00108863 00000200 0 00 00000000 00000210
beq_not 00208863 00000210 0 00 00000000 00000214
blt_taken fe114ce3 00000214 0 00 00000000 0000020c
blt_not fe20cce3 0000020c 0 00 00000000 00000210
bgeu_taken 00117863 00000210 0 00 00000000 00000220
bgeu_not 0020f863 00000220 0 00 00000000 00000224
jal 1000086f 00000300 1 10 00000304 00000400
jalr 003208e7 00000400 1 11 00000404 0000110e
addi_x0 00700013 00000500 1 00 00000007 00000504
add_x0 00100933 00000504 1 12 00000005 00000508
unknown 0000007f 00000508 0 00 00000000 0000050c

//--- exec_core.f
verilog/rv_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/data_ram.sv
verilog/exec_core.sv
bench/tb_clock.sv
bench/tb_exec_core.sv

//--- Bender.yml
package:
  name: exec_core

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/decoder.sv
      - verilog/reg_file.sv
      - verilog/alu.sv
      - verilog/data_ram.sv
      - verilog/exec_core.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_exec_core.sv
